/* Bender.yml */
package:
  name: risc8

sources:
  - include_dirs:
      - src
    files:
      - src/risc8_pkg.sv
      - src/risc8_decoder.sv
      - src/risc8_regs.sv
      - src/risc8_alu.sv
      - src/risc8_control.sv
      - src/risc8_core.sv
  - target: test
    files:
      - verification/risc8_mem_model.sv
      - verification/risc8_core_tb.sv

/* risc8.f */
+incdir+src
src/risc8_pkg.sv
src/risc8_decoder.sv
src/risc8_regs.sv
src/risc8_alu.sv
src/risc8_control.sv
src/risc8_core.sv
verification/risc8_mem_model.sv
verification/risc8_core_tb.sv

/* src/risc8_alu.sv */
// stage-two ALU: byte add/sub/logic, pair add/sub for pointers,
// SREG flag update with AVR rules
`timescale 1ns/1ps

module risc8_alu (
	input  risc8_pkg::alu_ctrl_t ctrl,
	input  logic [15:0]          rd,
	input  logic [7:0]           rr,
	input  logic [7:0]           sreg_in,
	output logic [15:0]          result,
	output logic [7:0]           sreg_out
);

	logic [7:0]  a;
	logic [7:0]  b;
	logic [7:0]  r;
	logic [15:0] w;
	logic        cin;
	logic        c;
	logic        h;
	logic        v;
	logic        n;
	logic        z;
	logic        wide;

	always_comb begin
		a = rd[7:0];
		// immediates and load data arrive as a constant
		b = ctrl.use_const ? ctrl.const_value : rr;
		cin = ctrl.use_carry & sreg_in[0];
		r = a;
		w = rd;
		// logic ops leave C and H alone and clear V
		c = sreg_in[0];
		h = sreg_in[5];
		v = 1'b0;

		case (ctrl.op)
		risc8_pkg::op_movr:
			r = b;
		risc8_pkg::op_add: begin
			r = a + b + {7'd0, cin};
			c = a[7] & b[7] | b[7] & ~r[7] | ~r[7] & a[7];
			h = a[3] & b[3] | b[3] & ~r[3] | ~r[3] & a[3];
			v = a[7] & b[7] & ~r[7] | ~a[7] & ~b[7] & r[7];
		end
		risc8_pkg::op_sub: begin
			r = a - b - {7'd0, cin};
			c = ~a[7] & b[7] | b[7] & r[7] | r[7] & ~a[7];
			h = ~a[3] & b[3] | b[3] & r[3] | r[3] & ~a[3];
			v = a[7] & ~b[7] & ~r[7] | ~a[7] & b[7] & r[7];
		end
		risc8_pkg::op_and:
			r = a & b;
		risc8_pkg::op_or:
			r = a | b;
		risc8_pkg::op_eor:
			r = a ^ b;
		risc8_pkg::op_adw: begin
			// ADIW style flags on the pair
			w = rd + {8'h00, b};
			v = ~rd[15] & w[15];
			c = rd[15] & ~w[15];
		end
		risc8_pkg::op_sbw: begin
			w = rd - {8'h00, b};
			v = rd[15] & ~w[15];
			c = w[15] & ~rd[15];
		end
		default:
			w = rd;
		endcase

		wide = ctrl.op inside {risc8_pkg::op_move, risc8_pkg::op_adw, risc8_pkg::op_sbw};
		result = wide ? w : {8'h00, r};
		n = wide ? w[15] : r[7];
		// SBC and CPC only keep Z when the earlier byte was zero too
		if (wide)
			z = w == 16'h0000;
		else
			z = r == 8'h00 && (!(ctrl.op == risc8_pkg::op_sub && ctrl.use_carry) || sreg_in[1]);

		sreg_out = sreg_in;
		// moves never touch flags
		if (!ctrl.keep_sreg && !(ctrl.op inside {risc8_pkg::op_move, risc8_pkg::op_movr}))
			sreg_out = {sreg_in[7:6], h, n ^ v, v, n, z, c};
	end

endmodule

/* src/risc8_control.sv */
// cycle sequencer with PC, SP, SREG, skip and fetch bubble state,
// micro-ops for stack and X accesses, data bus requests
// and the stage-two control word
`timescale 1ns/1ps
`include "risc8_defines.svh"

module risc8_control (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [15:0]          cdata,
	input  risc8_pkg::dec_t      dec,
	output logic [15:0]          opcode,
	output logic [15:0]          pc,
	output logic [5:0]           sel_a,
	output logic [5:0]           sel_b,
	input  logic [15:0]          reg_a,
	input  logic [7:0]           reg_b,
	input  logic [15:0]          alu_result,
	input  logic [7:0]           sreg_next,
	output risc8_pkg::alu_ctrl_t alu_ctrl,
	output logic [7:0]           sreg,
	output risc8_pkg::data_req_t data_req,
	input  logic [7:0]           data_read
);

	logic [15:0] pc_q;
	logic [15:0] next_pc;
	logic [15:0] jump_pc;
	logic        jump;
	logic [15:0] sp;
	logic [15:0] next_sp;
	logic [7:0]  sreg_d;
	logic [1:0]  cycle;
	logic [1:0]  next_cycle;
	logic        skip;
	logic        next_skip;
	// set after reset and after a taken RJMP/BRBx while the fetched word is stale
	logic        bubble;
	logic [7:0]  temp;
	logic [7:0]  temp_d;
	logic [15:0] prev_opcode;
	risc8_pkg::alu_ctrl_t ctrl_d;

	logic do_sp_push;
	logic do_sp_pop;
	logic do_alu_ldst;
	logic do_reg_ldst;
	logic do_data_load;

	logic        io_ext;
	logic [15:0] io_data_addr;

	// multi-cycle instructions replay their own opcode
	assign opcode = cycle == 2'd0 ? cdata : prev_opcode;
	// program memory sees the prefetch address every cycle
	assign pc = next_pc;

	assign io_ext = !(dec.io_addr inside {`RISC8_IO_SPL, `RISC8_IO_SPH, `RISC8_IO_SREG});
	assign io_data_addr = {8'h00, {2'b00, dec.io_addr} + `RISC8_IO_OFFSET};

	always_comb begin
		// a bubble refetches the current PC
		next_pc = bubble ? pc_q : pc_q + 16'd1;
		jump = 1'b0;
		jump_pc = pc_q + dec.simm12 + 16'd1;
		next_cycle = 2'd0;
		next_skip = 1'b0;
		next_sp = sp;
		sreg_d = sreg_next;
		temp_d = temp;
		data_req = '0;

		do_sp_push = 1'b0;
		do_sp_pop = 1'b0;
		do_alu_ldst = 1'b0;
		do_reg_ldst = 1'b0;
		do_data_load = 1'b0;

		// by default Rd and Rr are read and nothing retires
		ctrl_d = '0;
		ctrl_d.op = risc8_pkg::op_move;
		ctrl_d.dest = dec.rd;
		sel_a = dec.rd;
		sel_b = dec.rr;

		// skipped or stale words run one idle cycle
		if (!skip && !bubble) begin
			case (dec.cls)
			risc8_pkg::instr_alu: begin
				ctrl_d.op = dec.op;
				ctrl_d.use_carry = dec.carry;
				ctrl_d.compare = dec.compare;
				ctrl_d.store = 1'b1;
				if (dec.imm) begin
					sel_a = dec.rdi;
					ctrl_d.dest = dec.rdi;
					ctrl_d.use_const = 1'b1;
					ctrl_d.const_value = dec.k8;
				end
			end
			risc8_pkg::instr_ldi: begin
				ctrl_d.op = risc8_pkg::op_movr;
				ctrl_d.store = 1'b1;
				ctrl_d.use_const = 1'b1;
				ctrl_d.const_value = dec.k8;
				ctrl_d.dest = dec.rdi;
			end
			risc8_pkg::instr_rjmp:
				jump = 1'b1;
			risc8_pkg::instr_brbx: begin
				// flags of the instruction now in stage two
				jump_pc = pc_q + dec.simm7 + 16'd1;
				jump = sreg_next[dec.bit_sel] == dec.bit_val;
			end
			risc8_pkg::instr_cpse: begin
				// operands show up one cycle after the select
				if (cycle == 2'd0)
					next_cycle = 2'd1;
				else
					next_skip = reg_a[7:0] == reg_b;
			end
			risc8_pkg::instr_sbrx: begin
				if (cycle == 2'd0)
					next_cycle = 2'd1;
				else
					next_skip = reg_a[dec.bit_sel] == dec.bit_val;
			end
			risc8_pkg::instr_ld_x: begin
				sel_a = `RISC8_BASE_X;
				sel_b = dec.rd;
				ctrl_d.dest = `RISC8_BASE_X;
				if (cycle == 2'd0) begin
					// X +/- 1 written back while the access goes out
					next_cycle = 2'd1;
					ctrl_d.word = 1'b1;
					ctrl_d.use_const = 1'b1;
					ctrl_d.const_value = 8'd1;
					ctrl_d.keep_sreg = 1'b1;
					ctrl_d.op = dec.ptr_mode == 2'b10 ? risc8_pkg::op_sbw : risc8_pkg::op_adw;
					ctrl_d.store = dec.ptr_mode != 2'b00;
				end else if (cycle == 2'd1) begin
					// pre-decrement addresses with the ALU output
					do_alu_ldst = dec.ptr_mode == 2'b10;
					do_reg_ldst = dec.ptr_mode != 2'b10;
				end else begin
					ctrl_d.dest = dec.rd;
					do_data_load = 1'b1;
				end
			end
			risc8_pkg::instr_push: begin
				if (cycle == 2'd0) begin
					next_cycle = 2'd1;
				end else begin
					data_req.wdata = reg_a[7:0];
					do_sp_push = 1'b1;
				end
			end
			risc8_pkg::instr_pop: begin
				if (cycle == 2'd0) begin
					do_sp_pop = 1'b1;
					next_cycle = 2'd1;
				end else begin
					do_data_load = 1'b1;
				end
			end
			risc8_pkg::instr_rcall: begin
				// return address PC+1 goes out low byte first
				if (cycle == 2'd0) begin
					data_req.wdata = next_pc[7:0];
					do_sp_push = 1'b1;
					next_cycle = 2'd1;
				end else if (cycle == 2'd1) begin
					data_req.wdata = next_pc[15:8];
					do_sp_push = 1'b1;
					next_cycle = 2'd2;
				end else begin
					next_pc = pc_q + dec.simm12 + 16'd1;
				end
			end
			risc8_pkg::instr_ret: begin
				// high byte pops first
				if (cycle == 2'd0) begin
					do_sp_pop = 1'b1;
					next_cycle = 2'd1;
				end else if (cycle == 2'd1) begin
					do_sp_pop = 1'b1;
					temp_d = data_read;
					next_cycle = 2'd2;
				end else begin
					next_pc = {temp, data_read};
				end
			end
			risc8_pkg::instr_in: begin
				if (cycle == 2'd0) begin
					data_req.addr = io_data_addr;
					data_req.ren = io_ext;
					next_cycle = 2'd1;
				end else begin
					ctrl_d.op = risc8_pkg::op_movr;
					ctrl_d.store = 1'b1;
					ctrl_d.use_const = 1'b1;
					case (dec.io_addr)
					`RISC8_IO_SPL:
						ctrl_d.const_value = sp[7:0];
					`RISC8_IO_SPH:
						ctrl_d.const_value = sp[15:8];
					`RISC8_IO_SREG:
						ctrl_d.const_value = sreg;
					default:
						ctrl_d.const_value = data_read;
					endcase
				end
			end
			risc8_pkg::instr_out: begin
				if (cycle == 2'd0) begin
					next_cycle = 2'd1;
				end else begin
					data_req.addr = io_data_addr;
					data_req.wdata = reg_a[7:0];
					data_req.wen = io_ext;
					case (dec.io_addr)
					`RISC8_IO_SPL:
						next_sp[7:0] = reg_a[7:0];
					`RISC8_IO_SPH:
						next_sp[15:8] = reg_a[7:0];
					`RISC8_IO_SREG:
						sreg_d = reg_a[7:0];
					default: ;
					endcase
				end
			end
			default: ;
			endcase
		end

		// push writes at SP then decrements
		if (do_sp_push) begin
			data_req.wen = 1'b1;
			data_req.addr = sp;
			next_sp = sp - 16'd1;
		end
		// pop increments then reads
		if (do_sp_pop) begin
			data_req.ren = 1'b1;
			data_req.addr = sp + 16'd1;
			next_sp = sp + 16'd1;
		end
		if (do_alu_ldst || do_reg_ldst) begin
			data_req.addr = do_alu_ldst ? alu_result : reg_a;
			if (dec.st) begin
				data_req.wen = 1'b1;
				data_req.wdata = reg_b;
			end else begin
				// load needs one more cycle for the data
				data_req.ren = 1'b1;
				next_cycle = 2'd2;
			end
		end
		// read data retires through the ALU as a constant
		if (do_data_load) begin
			ctrl_d.op = risc8_pkg::op_movr;
			ctrl_d.store = 1'b1;
			ctrl_d.use_const = 1'b1;
			ctrl_d.const_value = data_read;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= 16'h0000;
			sp <= `RISC8_SP_RESET;
			sreg <= 8'h00;
			cycle <= 2'd0;
			skip <= 1'b0;
			bubble <= 1'b1;
			alu_ctrl <= '0;
		end else begin
			// taken RJMP/BRBx lands in pc_q and costs one bubble
			if (jump)
				pc_q <= jump_pc;
			else if (next_cycle == 2'd0)
				pc_q <= next_pc;
			bubble <= jump;
			sp <= next_sp;
			sreg <= sreg_d;
			cycle <= next_cycle;
			skip <= next_skip;
			alu_ctrl <= ctrl_d;
		end
	end

	always_ff @(posedge clk) begin
		prev_opcode <= opcode;
		temp <= temp_d;
	end

	// memory model takes one access per cycle
	a_one_access: assert property (@(posedge clk) disable iff (reset)
		!(data_req.wen && data_req.ren));

	// only LD, RCALL and RET run a third cycle on the replayed opcode
	a_cycle_range: assert property (@(posedge clk) disable iff (reset)
		cycle == 2'd2 |-> dec.cls inside {risc8_pkg::instr_rcall, risc8_pkg::instr_ret}
			|| dec.cls == risc8_pkg::instr_ld_x && !dec.st);

endmodule

/* src/risc8_core.sv */
// top level of the two-stage core: decoder, sequencer,
// register file and ALU
`timescale 1ns/1ps

module risc8_core (
	input  logic                 clk,
	input  logic                 reset,
	output logic [15:0]          pc,
	input  logic [15:0]          cdata,
	output risc8_pkg::data_req_t data_req,
	input  logic [7:0]           data_read
);

	risc8_pkg::dec_t      dec;
	risc8_pkg::alu_ctrl_t alu_ctrl;
	logic [15:0]          opcode;
	logic [5:0]           sel_a;
	logic [5:0]           sel_b;
	logic [15:0]          reg_a;
	logic [7:0]           reg_b;
	logic [15:0]          alu_result;
	logic [7:0]           sreg_next;
	logic [7:0]           sreg;

	risc8_decoder u_decoder (
		.opcode (opcode),
		.dec    (dec)
	);

	risc8_control u_control (
		.clk        (clk),
		.reset      (reset),
		.cdata      (cdata),
		.dec        (dec),
		.opcode     (opcode),
		.pc         (pc),
		.sel_a      (sel_a),
		.sel_b      (sel_b),
		.reg_a      (reg_a),
		.reg_b      (reg_b),
		.alu_result (alu_result),
		.sreg_next  (sreg_next),
		.alu_ctrl   (alu_ctrl),
		.sreg       (sreg),
		.data_req   (data_req),
		.data_read  (data_read)
	);

	// writeback from stage two, compares keep their result off the file
	risc8_regs u_regs (
		.clk     (clk),
		.reset   (reset),
		.sel_a   (sel_a),
		.sel_b   (sel_b),
		.reg_a   (reg_a),
		.reg_b   (reg_b),
		.wr_sel  (alu_ctrl.dest),
		.wr_data (alu_result),
		.wr_en   (alu_ctrl.store && !alu_ctrl.compare),
		.wr_word (alu_ctrl.word)
	);

	risc8_alu u_alu (
		.ctrl     (alu_ctrl),
		.rd       (reg_a),
		.rr       (reg_b),
		.sreg_in  (sreg),
		.result   (alu_result),
		.sreg_out (sreg_next)
	);

endmodule

/* src/risc8_decoder.sv */
// opcode classifier: AVR bit patterns to instruction class,
// ALU operation, register and immediate fields
`timescale 1ns/1ps

module risc8_decoder (
	input  logic [15:0]     opcode,
	output risc8_pkg::dec_t dec
);

	always_comb begin
		dec = '0;
		dec.cls = risc8_pkg::instr_invalid;
		dec.op = risc8_pkg::op_move;

		// field extraction is the same for every format
		dec.rd = {1'b0, opcode[8:4]};
		dec.rr = {1'b0, opcode[9], opcode[3:0]};
		// immediate forms only reach the upper sixteen registers
		dec.rdi = {2'b01, opcode[7:4]};
		dec.k8 = {opcode[11:8], opcode[3:0]};
		dec.simm12 = {{4{opcode[11]}}, opcode[11:0]};
		dec.simm7 = {{9{opcode[9]}}, opcode[9:3]};
		dec.bit_sel = opcode[2:0];
		// SBRS skips on a set bit
		dec.bit_val = opcode[9];
		dec.io_addr = {opcode[10:9], opcode[3:0]};
		dec.st = opcode[9];
		dec.ptr_mode = opcode[1:0];

		// carry-in users are CPC, SBC, ADC and SBCI
		dec.carry = opcode[15:10] inside {6'b000001, 6'b000010, 6'b000111}
			|| opcode[15:12] == 4'b0100;
		// CPC, CP and CPI only set flags
		dec.compare = opcode[15:10] inside {6'b000001, 6'b000101}
			|| opcode[15:12] == 4'b0011;
		// CPI, SBCI, SUBI, ORI, ANDI
		dec.imm = opcode[15:12] inside {4'b0011, 4'b0100, 4'b0101, 4'b0110, 4'b0111};

		// ALU operation from the upper six bits
		casez (opcode[15:10])
		6'b000001, 6'b000010, 6'b000101, 6'b000110,
		6'b0011??, 6'b0100??, 6'b0101??:
			dec.op = risc8_pkg::op_sub;
		6'b000011, 6'b000111:
			dec.op = risc8_pkg::op_add;
		6'b001000, 6'b0111??:
			dec.op = risc8_pkg::op_and;
		6'b001001:
			dec.op = risc8_pkg::op_eor;
		6'b001010, 6'b0110??:
			dec.op = risc8_pkg::op_or;
		6'b001011, 6'b1110??:
			dec.op = risc8_pkg::op_movr;
		default:
			dec.op = risc8_pkg::op_move;
		endcase

		casez (opcode)
		16'b0000_01??_????_????, 16'b0000_1???_????_????,
		16'b0001_01??_????_????, 16'b0001_1???_????_????,
		16'b001?_????_????_????, 16'b01??_????_????_????:
			dec.cls = risc8_pkg::instr_alu;
		16'b0001_00??_????_????:
			dec.cls = risc8_pkg::instr_cpse;
		16'b1110_????_????_????:
			dec.cls = risc8_pkg::instr_ldi;
		16'b1100_????_????_????:
			dec.cls = risc8_pkg::instr_rjmp;
		16'b1101_????_????_????:
			dec.cls = risc8_pkg::instr_rcall;
		16'b1111_0???_????_????: begin
			// BRBS has bit 10 clear, BRBC set
			dec.cls = risc8_pkg::instr_brbx;
			dec.bit_val = ~opcode[10];
		end
		16'b1111_11??_????_0???:
			dec.cls = risc8_pkg::instr_sbrx;
		16'b1001_00??_????_1100, 16'b1001_00??_????_1101, 16'b1001_00??_????_1110:
			dec.cls = risc8_pkg::instr_ld_x;
		16'b1001_001?_????_1111:
			dec.cls = risc8_pkg::instr_push;
		16'b1001_000?_????_1111:
			dec.cls = risc8_pkg::instr_pop;
		16'b1001_0101_0000_1000:
			dec.cls = risc8_pkg::instr_ret;
		16'b1011_0???_????_????:
			dec.cls = risc8_pkg::instr_in;
		16'b1011_1???_????_????:
			dec.cls = risc8_pkg::instr_out;
		default:
			dec.cls = risc8_pkg::instr_invalid;
		endcase
	end

endmodule

/* src/risc8_defines.svh */
// core constants: stack pointer reset value, I/O window offset,
// pointer register base and the I/O addresses kept inside the core
`ifndef RISC8_DEFINES_SVH
`define RISC8_DEFINES_SVH

// stack grows down from the top of the 4 KB data window
`define RISC8_SP_RESET 16'h1000

// I/O address n lives at data address n + 0x20
`define RISC8_IO_OFFSET 8'h20

// XL is r26, XH is r27
`define RISC8_BASE_X 6'd26

// I/O registers that never reach the data bus
`define RISC8_IO_SPL 6'h3D
`define RISC8_IO_SPH 6'h3E
`define RISC8_IO_SREG 6'h3F

`endif

/* src/risc8_pkg.sv */
// shared types: instruction class and ALU opcode enums,
// stage-two control word, data bus request, decoder output
package risc8_pkg;

	// instruction classes seen by the sequencer
	typedef enum logic [4:0] {
		instr_alu,
		instr_ldi,
		instr_rjmp,
		instr_brbx,
		instr_cpse,
		instr_sbrx,
		instr_ld_x,
		instr_push,
		instr_pop,
		instr_rcall,
		instr_ret,
		instr_in,
		instr_out,
		instr_invalid
	} instr_e;

	// move passes the 16-bit Rd pair, movr passes the second operand
	typedef enum logic [3:0] {
		op_move,
		op_movr,
		op_add,
		op_sub,
		op_and,
		op_or,
		op_eor,
		op_adw,
		op_sbw
	} alu_op_e;

	// everything stage two needs, registered at the end of decode
	typedef struct packed {
		alu_op_e    op;
		logic       use_carry;
		logic       keep_sreg;
		logic       store;
		logic       word;
		logic       use_const;
		logic [7:0] const_value;
		logic [5:0] dest;
		// flags only, result is dropped
		logic       compare;
	} alu_ctrl_t;

	// one request per cycle, read data follows one clock later
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wen;
		logic        ren;
	} data_req_t;

	typedef struct packed {
		instr_e      cls;
		alu_op_e     op;
		logic        carry;
		logic        compare;
		// second operand comes from K, Rd is r16..r31
		logic        imm;
		logic [5:0]  rd;
		logic [5:0]  rr;
		logic [5:0]  rdi;
		logic [7:0]  k8;
		logic [15:0] simm12;
		logic [15:0] simm7;
		logic [2:0]  bit_sel;
		logic        bit_val;
		logic [5:0]  io_addr;
		// ST rather than LD
		logic        st;
		// X addressing: 00 plain, 01 post-increment, 10 pre-decrement
		logic [1:0]  ptr_mode;
	} dec_t;

endpackage

/* src/risc8_regs.sv */
// 32 x 8 register file in flops with registered reads:
// 16-bit pair port, 8-bit port, byte or pair write with bypass
`timescale 1ns/1ps

module risc8_regs (
	input  logic        clk,
	input  logic        reset,
	input  logic [5:0]  sel_a,
	input  logic [5:0]  sel_b,
	output logic [15:0] reg_a,
	output logic [7:0]  reg_b,
	input  logic [5:0]  wr_sel,
	input  logic [15:0] wr_data,
	input  logic        wr_en,
	input  logic        wr_word
);

	logic [7:0] mem [32];

	// the byte a read sees after this edge, so an instruction
	// retiring now is visible to the one decoding now
	function automatic logic [7:0] fwd_byte(input logic [4:0] idx);
		logic [4:0] hi_sel;
		hi_sel = wr_sel[4:0] + 5'd1;
		if (wr_en && wr_sel[4:0] == idx)
			return wr_data[7:0];
		if (wr_en && wr_word && hi_sel == idx)
			return wr_data[15:8];
		return mem[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_sel[4:0]] <= wr_data[7:0];
			// pair writes also fill the odd byte above
			if (wr_word)
				mem[wr_sel[4:0] + 5'd1] <= wr_data[15:8];
		end
		reg_a <= {fwd_byte(sel_a[4:0] + 5'd1), fwd_byte(sel_a[4:0])};
		reg_b <= fwd_byte(sel_b[4:0]);
	end

	// pointer pairs are even aligned, an odd base would split X
	a_word_even: assert property (@(posedge clk) disable iff (reset)
		wr_en && wr_word |-> !wr_sel[0]);

endmodule

/* verification/risc8_core_tb.sv */
// core testbench: program built from encoders, LFSR immediates,
// AVR flag model for expected values, expected write table check
`timescale 1ns/1ps

module risc8_core_tb;

	logic                 clk;
	logic                 reset;
	logic [15:0]          pc;
	logic [15:0]          cdata;
	risc8_pkg::data_req_t data_req;
	logic [7:0]           data_read;
	logic                 log_valid;
	logic [15:0]          log_addr;
	logic [7:0]           log_data;

	logic [15:0] prog [$];
	// {address, value} of each expected data bus write
	logic [23:0] exp_wr [$];
	logic [15:0] lfsr;
	logic [7:0]  tb_sreg;
	logic        io_read_seen;

	// reg-reg opcodes: ADD SUB AND OR EOR ADC SBC
	logic [5:0] alu_op6 [7] = '{6'b000011, 6'b000110, 6'b001000, 6'b001010,
		6'b001001, 6'b000111, 6'b000010};

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		io_read_seen = 1'b0;
	end

	always #10 clk = ~clk;

	risc8_core UUT (
		.clk       (clk),
		.reset     (reset),
		.pc        (pc),
		.cdata     (cdata),
		.data_req  (data_req),
		.data_read (data_read)
	);

	risc8_mem_model u_mem (
		.clk       (clk),
		.pc        (pc),
		.cdata     (cdata),
		.data_req  (data_req),
		.data_read (data_read),
		.log_valid (log_valid),
		.log_addr  (log_addr),
		.log_data  (log_data)
	);

	// external IN must show up as a read at I/O address + 0x20
	always @(negedge clk)
		if (!reset && data_req.ren === 1'b1 && data_req.addr == 16'h0025)
			io_read_seen <= 1'b1;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_byte(output logic [7:0] v);
		v = 8'h00;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	// expected {sreg, result} with the AVR flag rules
	function automatic logic [15:0] alu_model(input int kind, input logic [7:0] a,
		input logic [7:0] b, input logic [7:0] s);
		logic [8:0] full;
		logic [7:0] r;
		logic       cin;
		logic       c;
		logic       z;
		logic       n;
		logic       v;
		logic       h;
		cin = (kind == 5 || kind == 6) ? s[0] : 1'b0;
		c = s[0];
		h = s[5];
		v = 1'b0;
		r = 8'h00;
		case (kind)
		0, 5: begin
			full = a + b + cin;
			r = full[7:0];
			c = full[8];
			h = int'(a[3:0]) + int'(b[3:0]) + int'(cin) > 15;
			v = a[7] == b[7] && r[7] != a[7];
		end
		1, 6: begin
			full = {1'b0, a} - {1'b0, b} - cin;
			r = full[7:0];
			c = int'(b) + int'(cin) > int'(a);
			h = int'(b[3:0]) + int'(cin) > int'(a[3:0]);
			v = a[7] != b[7] && r[7] != a[7];
		end
		2: r = a & b;
		3: r = a | b;
		default: r = a ^ b;
		endcase
		// SBC keeps Z only if it was already set
		z = r == 8'h00 && (kind != 6 || s[1]);
		n = r[7];
		return {s[7:6], h, n ^ v, v, n, z, c, r};
	endfunction

	function automatic logic [15:0] enc_imm(input logic [3:0] op4, input logic [4:0] d,
		input logic [7:0] k);
		return {op4, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic logic [15:0] enc_rr(input logic [5:0] op6, input logic [4:0] d,
		input logic [4:0] r);
		return {op6, r[4], d, r[3:0]};
	endfunction

	function automatic logic [15:0] enc_io(input logic out, input logic [4:0] r,
		input logic [5:0] a);
		return {4'b1011, out, a[5:4], r, a[3:0]};
	endfunction

	function automatic logic [15:0] enc_br(input logic clr, input logic [2:0] s,
		input logic [6:0] k);
		return {5'b11110, clr, k, s};
	endfunction

	function automatic logic [15:0] enc_sbr(input logic set, input logic [4:0] r,
		input logic [2:0] b);
		return {6'b111111, set, r, 1'b0, b};
	endfunction

	// mode 0 plain, 1 post-increment, 2 pre-decrement
	function automatic logic [15:0] enc_ldst(input logic st, input logic [4:0] r,
		input logic [1:0] mode);
		return {6'b100100, st, r, 2'b11, mode};
	endfunction

	task automatic emit(input logic [15:0] w);
		prog.push_back(w);
	endtask

	task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
		exp_wr.push_back({a, d});
	endtask

	// a distinct value through r19 to I/O 0x01
	task automatic marker(input logic [7:0] v);
		emit(enc_imm(4'hE, 5'd19, v));
		emit(enc_io(1'b1, 5'd19, 6'h01));
		expect_write(16'h0021, v);
	endtask

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	initial begin
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] m;
		int          p;
		int          cnt;
		lfsr = 16'd25;
		tb_sreg = 8'h00;
		// r23 holds the value that only wrong paths emit
		emit(enc_imm(4'hE, 5'd23, 8'hEE));

		// ALU ops, result then SREG out to 0x21
		for (int k = 0; k < 7; k++) begin
			rand_byte(a);
			rand_byte(b);
			emit(enc_imm(4'hE, 5'd16, a));
			emit(enc_imm(4'hE, 5'd17, b));
			emit(enc_rr(alu_op6[k], 5'd16, 5'd17));
			emit(enc_io(1'b1, 5'd16, 6'h01));
			emit(enc_io(1'b0, 5'd20, 6'h3F));
			emit(enc_io(1'b1, 5'd20, 6'h01));
			m = alu_model(k, a, b, tb_sreg);
			tb_sreg = m[15:8];
			expect_write(16'h0021, m[7:0]);
			expect_write(16'h0021, tb_sreg);
		end

		// branches, BREQ taken and not taken, BRCC not taken and taken, RJMP
		emit(enc_imm(4'hE, 5'd16, 8'h40));
		emit(enc_imm(4'h3, 5'd16, 8'h40));
		emit(enc_br(1'b0, 3'd1, 7'd1));
		emit(enc_io(1'b1, 5'd23, 6'h01));
		marker(8'hB1);
		emit(enc_imm(4'h3, 5'd16, 8'h41));
		emit(enc_br(1'b0, 3'd1, 7'd2));
		marker(8'hB2);
		emit(enc_imm(4'h3, 5'd16, 8'h41));
		emit(enc_br(1'b1, 3'd0, 7'd2));
		marker(8'hB3);
		emit(enc_imm(4'h3, 5'd16, 8'h30));
		emit(enc_br(1'b1, 3'd0, 7'd1));
		emit(enc_io(1'b1, 5'd23, 6'h01));
		marker(8'hB4);
		emit({4'hC, 12'd1});
		emit(enc_io(1'b1, 5'd23, 6'h01));
		marker(8'hB5);

		// skips on 0x5A, taken ones hide an OUT of r23
		emit(enc_imm(4'hE, 5'd21, 8'h5A));
		emit(enc_imm(4'hE, 5'd22, 8'h5A));
		emit(enc_rr(6'b000100, 5'd21, 5'd22));
		emit(enc_io(1'b1, 5'd23, 6'h01));
		marker(8'hC1);
		emit(enc_imm(4'hE, 5'd22, 8'h5B));
		emit(enc_rr(6'b000100, 5'd21, 5'd22));
		emit(enc_io(1'b1, 5'd21, 6'h01));
		expect_write(16'h0021, 8'h5A);
		emit(enc_sbr(1'b0, 5'd21, 3'd0));
		emit(enc_io(1'b1, 5'd23, 6'h01));
		marker(8'hC2);
		emit(enc_sbr(1'b0, 5'd21, 3'd1));
		emit(enc_io(1'b1, 5'd21, 6'h01));
		expect_write(16'h0021, 8'h5A);
		emit(enc_sbr(1'b1, 5'd21, 3'd3));
		emit(enc_io(1'b1, 5'd23, 6'h01));
		marker(8'hC3);
		emit(enc_sbr(1'b1, 5'd21, 3'd2));
		emit(enc_io(1'b1, 5'd21, 6'h01));
		expect_write(16'h0021, 8'h5A);

		// stores through X = 0x0200
		emit(enc_imm(4'hE, 5'd26, 8'h00));
		emit(enc_imm(4'hE, 5'd27, 8'h02));
		emit(enc_imm(4'hE, 5'd24, 8'h11));
		emit(enc_ldst(1'b1, 5'd24, 2'd0));
		expect_write(16'h0200, 8'h11);
		emit(enc_imm(4'hE, 5'd24, 8'h22));
		emit(enc_ldst(1'b1, 5'd24, 2'd1));
		expect_write(16'h0200, 8'h22);
		emit(enc_imm(4'hE, 5'd24, 8'h33));
		emit(enc_ldst(1'b1, 5'd24, 2'd1));
		expect_write(16'h0201, 8'h33);
		emit(enc_imm(4'hE, 5'd24, 8'h44));
		emit(enc_ldst(1'b1, 5'd24, 2'd2));
		expect_write(16'h0201, 8'h44);
		// loads from the preloaded bytes at 0x0300
		emit(enc_imm(4'hE, 5'd27, 8'h03));
		emit(enc_imm(4'hE, 5'd26, 8'h00));
		emit(enc_ldst(1'b0, 5'd25, 2'd0));
		emit(enc_io(1'b1, 5'd25, 6'h01));
		expect_write(16'h0021, 8'h9C);
		emit(enc_ldst(1'b0, 5'd25, 2'd1));
		emit(enc_ldst(1'b0, 5'd25, 2'd0));
		emit(enc_io(1'b1, 5'd25, 6'h01));
		expect_write(16'h0021, 8'h3E);

		// push, push, pop, pop
		emit(enc_imm(4'hE, 5'd24, 8'h77));
		emit({7'b1001001, 5'd24, 4'hF});
		expect_write(16'h1000, 8'h77);
		emit(enc_imm(4'hE, 5'd24, 8'h88));
		emit({7'b1001001, 5'd24, 4'hF});
		expect_write(16'h0FFF, 8'h88);
		for (int i = 0; i < 2; i++) begin
			emit({7'b1001000, 5'd28, 4'hF});
			emit(enc_io(1'b1, 5'd28, 6'h01));
		end
		expect_write(16'h0021, 8'h88);
		expect_write(16'h0021, 8'h77);

		// rcall to a subroutine after the code that follows it
		p = prog.size();
		emit({4'hD, 12'd3});
		emit(enc_imm(4'hE, 5'd19, 8'hD2));
		emit(enc_io(1'b1, 5'd19, 6'h01));
		emit({4'hC, 12'd3});
		emit(enc_imm(4'hE, 5'd19, 8'hD1));
		emit(enc_io(1'b1, 5'd19, 6'h01));
		emit(16'h9508);
		m = p + 1;
		expect_write(16'h1000, m[7:0]);
		expect_write(16'h0FFF, m[15:8]);
		expect_write(16'h0021, 8'hD1);
		expect_write(16'h0021, 8'hD2);

		// SPL = 0x80 moves the next push to 0x1080
		emit(enc_imm(4'hE, 5'd24, 8'h80));
		emit(enc_io(1'b1, 5'd24, 6'h3D));
		emit(enc_imm(4'hE, 5'd24, 8'h99));
		emit({7'b1001001, 5'd24, 4'hF});
		expect_write(16'h1080, 8'h99);
		emit(enc_io(1'b0, 5'd29, 6'h05));
		emit(enc_io(1'b1, 5'd29, 6'h01));
		expect_write(16'h0021, 8'h6B);

		#1;
		foreach (prog[i])
			u_mem.rom[i] = prog[i];
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		// first cycle after reset still fetches from 0 with a quiet bus
		@(negedge clk);
		assert (pc == 16'h0000 && data_req.wen == 1'b0 && data_req.ren == 1'b0)
		else stop_run("pc not zero or data bus active right after reset");

		foreach (exp_wr[i]) begin
			cnt = 0;
			do begin
				@(negedge clk);
				cnt++;
			end while (!log_valid && cnt < 200);
			assert (log_valid)
			else stop_run($sformatf("no data bus write %0d seen within 200 cycles", i));
			assert (log_addr == exp_wr[i][23:8])
			else stop_run($sformatf("ERR time=%0t log_addr expected=%h got=%h",
				$time, exp_wr[i][23:8], log_addr));
			assert (log_data == exp_wr[i][7:0])
			else stop_run($sformatf("ERR time=%0t log_data expected=%h got=%h",
				$time, exp_wr[i][7:0], log_data));
		end
		assert (io_read_seen)
		else stop_run("IN from I/O 0x05 never read data address 0x0025");
		$display("Simulation passed");
		$finish;
	end

endmodule

/* verification/risc8_mem_model.sv */
// program ROM and data RAM models for the core testbench,
// both with registered read data, plus a log of every data write
`timescale 1ns/1ps

module risc8_mem_model (
	input  logic                 clk,
	input  logic [15:0]          pc,
	output logic [15:0]          cdata,
	input  risc8_pkg::data_req_t data_req,
	output logic [7:0]           data_read,
	output logic                 log_valid,
	output logic [15:0]          log_addr,
	output logic [7:0]           log_data
);

	// 256 program words, the testbench writes the program in
	logic [15:0] rom [256];
	// covers the stack region above 0x1000 too
	logic [7:0]  ram [8192];

	initial begin
		// unused words are rjmp .-1 so the core parks itself
		for (int i = 0; i < 256; i++)
			rom[i] = 16'hCFFF;
		for (int i = 0; i < 8192; i++)
			ram[i] = 8'h00;
		// bytes for LD through X
		ram[16'h0300] = 8'h9C;
		ram[16'h0301] = 8'h3E;
		// external input register at I/O 0x05
		ram[16'h0025] = 8'h6B;
		cdata = 16'h0000;
		data_read = 8'h00;
		log_valid = 1'b0;
		log_addr = 16'h0000;
		log_data = 8'h00;
	end

	always @(posedge clk) begin
		cdata <= rom[pc[7:0]];
		// one write event per clock, held for a full cycle
		log_valid <= data_req.wen === 1'b1;
		log_addr <= data_req.addr;
		log_data <= data_req.wdata;
		if (data_req.wen === 1'b1)
			ram[data_req.addr[12:0]] <= data_req.wdata;
		if (data_req.ren === 1'b1)
			data_read <= ram[data_req.addr[12:0]];
	end

endmodule
